//--- build.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
    --top-module tb_key_extract -o sim_key_extract
./obj_dir/sim_key_extract | tee sim.log

if grep -qx "TESTS PASSED" sim.log; then
    echo "simulation ok"
else
    echo "simulation reported failure"
    exit 1
fi

//--- common/extract_if.sv
`timescale 1ns/1ps
`default_nettype none

// decoded PHV plus both table entries, stable between strobes
interface extract_if import key_extract_pkg::*; ();

    logic               valid;
    logic [phv_len-1:0] phv;
    containers_t        conts;
    key_off_t           key_off;
    key_mask_t          key_mask;

    modport decode (
        output valid,
        output phv,
        output conts,
        output key_off,
        output key_mask
    );

    modport build (
        input valid,
        input phv,
        input conts,
        input key_off,
        input key_mask
    );

endinterface

`default_nettype wire

//--- common/key_extract_pkg.sv
`default_nettype none

package key_extract_pkg;

    typedef logic [47:0] cont6_t;
    typedef logic [31:0] cont4_t;
    typedef logic [15:0] cont2_t;

    // 6B block sits at the top of the PHV, slot 7 first
    typedef struct packed {
        cont6_t [7:0] c6;
        cont4_t [7:0] c4;
        cont2_t [7:0] c2;
    } containers_t;

    localparam int meta_len = 256;
    localparam int phv_len = $bits(containers_t) + meta_len;

    // vlan index inside the metadata
    localparam int vlan_lo = 129;
    localparam int vlan_hi = 140;

    // operand type codes, code 3 reads as zero
    localparam logic [1:0] type_2b = 2'd0;
    localparam logic [1:0] type_4b = 2'd1;
    localparam logic [1:0] type_6b = 2'd2;

    // opcodes, code 3 is always true
    localparam logic [1:0] op_gt = 2'd0;
    localparam logic [1:0] op_ge = 2'd1;
    localparam logic [1:0] op_eq = 2'd2;

    // val is the immediate, or {3'b0, type[1:0], index[2:0]}
    typedef struct packed {
        logic       imm;
        logic [7:0] val;
    } operand_t;

    typedef struct packed {
        logic [1:0] opcode;
        operand_t   a;
        operand_t   b;
    } cmp_op_t;

    typedef struct packed {
        logic [2:0] sel6_0;
        logic [2:0] sel6_1;
        logic [2:0] sel4_0;
        logic [2:0] sel4_1;
        logic [2:0] sel2_0;
        logic [2:0] sel2_1;
        cmp_op_t    cmp;
    } key_off_t;

    typedef struct packed {
        cont6_t k6_0;
        cont6_t k6_1;
        cont4_t k4_0;
        cont4_t k4_1;
        cont2_t k2_0;
        cont2_t k2_1;
        logic   cmp;
    } key_t;

    localparam int key_len = $bits(key_t);

    typedef logic [key_len-1:0] key_mask_t;

endpackage

`default_nettype wire

//--- common/key_if.sv
`timescale 1ns/1ps
`default_nettype none

// unmasked key with its mask and PHV
interface key_if import key_extract_pkg::*; ();

    logic               valid;
    key_t               key;
    key_mask_t          key_mask;
    logic [phv_len-1:0] phv;

    modport build (
        output valid,
        output key,
        output key_mask,
        output phv
    );

    modport out (
        input valid,
        input key,
        input key_mask,
        input phv
    );

endinterface

`default_nettype wire

//--- key_extract/key_build.sv
`timescale 1ns/1ps
`default_nettype none

module key_build import key_extract_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    extract_if.build ext,
    key_if.build     key
);

    key_off_t   off;
    cmp_op_t    cmp;
    logic [7:0] opnd_a;
    logic [7:0] opnd_b;
    logic       opnd_valid;
    logic       key_valid;
    logic       cmp_bit;
    key_t       key_r;

    // immediate, or low byte of the selected container
    function automatic logic [7:0] fetch(input operand_t opnd, input containers_t conts);
        logic [2:0] idx;
        logic [7:0] res;
        idx = opnd.val[2:0];
        if (opnd.imm) begin
            res = opnd.val;
        end else begin
            case (opnd.val[4:3])
                type_6b: res = conts.c6[idx][7:0];
                type_4b: res = conts.c4[idx][7:0];
                type_2b: res = conts.c2[idx][7:0];
                default: res = 8'd0;
            endcase
        end
        return res;
    endfunction

    assign off = ext.key_off;
    assign cmp = off.cmp;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opnd_valid <= 1'b0;
            key_valid  <= 1'b0;
        end else begin
            opnd_valid <= ext.valid;
            key_valid  <= opnd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ext.valid) begin
            opnd_a <= fetch(cmp.a, ext.conts);
            opnd_b <= fetch(cmp.b, ext.conts);
        end
    end

    always_comb begin
        case (cmp.opcode)
            op_gt:   cmp_bit = opnd_a > opnd_b;
            op_ge:   cmp_bit = opnd_a >= opnd_b;
            op_eq:   cmp_bit = opnd_a == opnd_b;
            default: cmp_bit = 1'b1;
        endcase
    end

    // containers stay put until the next PHV, so read them again here
    always_ff @(posedge clk) begin
        if (opnd_valid) begin
            key_r.k6_0 <= ext.conts.c6[off.sel6_0];
            key_r.k6_1 <= ext.conts.c6[off.sel6_1];
            key_r.k4_0 <= ext.conts.c4[off.sel4_0];
            key_r.k4_1 <= ext.conts.c4[off.sel4_1];
            key_r.k2_0 <= ext.conts.c2[off.sel2_0];
            key_r.k2_1 <= ext.conts.c2[off.sel2_1];
            key_r.cmp  <= cmp_bit;
        end
    end

    assign key.valid    = key_valid;
    assign key.key      = key_r;
    assign key.key_mask = ext.key_mask;
    assign key.phv      = ext.phv;

endmodule

`default_nettype wire

//--- key_extract/key_output.sv
`timescale 1ns/1ps
`default_nettype none

module key_output import key_extract_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    key_if.out                 key,
    input  logic               ready_in,
    output logic               phv_release,
    output logic [phv_len-1:0] phv_out,
    output logic               phv_valid_out,
    output logic               key_valid_out,
    output logic [key_len-1:0] key_out_masked,
    output logic [key_len-1:0] key_mask_out
);

    logic pending;
    logic emit;
    logic out_valid;

    // result waits in key_build's registers while pending
    assign emit = (key.valid || pending) && ready_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= emit;
            if (emit) begin
                pending <= 1'b0;
            end else if (key.valid) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            phv_out        <= key.phv;
            key_out_masked <= key.key & ~key.key_mask;
            key_mask_out   <= key.key_mask;
        end
    end

    assign phv_valid_out = out_valid;
    assign key_valid_out = out_valid;
    assign phv_release   = out_valid;

endmodule

`default_nettype wire

//--- key_extract/key_table.sv
`timescale 1ns/1ps
`default_nettype none

module key_table #(
    parameter int  table_aw = 5,
    parameter type entry_t  = logic [7:0]
) (
    input  logic                clk,
    input  logic                wr,
    input  logic [table_aw-1:0] wr_addr,
    input  logic [table_aw-1:0] rd_addr,
    input  entry_t              wr_data,
    output entry_t              rd_data
);

    localparam int depth = 2 ** table_aw;

    entry_t mem [depth];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- key_extract/phv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module phv_decode import key_extract_pkg::*; #(
    parameter int table_aw = 5
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [phv_len-1:0]  phv_in,
    input  logic                phv_valid_in,
    output logic                ready_out,
    input  logic                phv_release,
    input  logic                cfg_off_wr,
    input  logic                cfg_mask_wr,
    input  logic [table_aw-1:0] cfg_addr,
    input  key_off_t            cfg_off_data,
    input  key_mask_t           cfg_mask_data,
    extract_if.decode           ext
);

    logic                       busy;
    logic                       accept;
    logic                       lookup;
    logic [phv_len-1:0]         phv_r;
    containers_t                conts_r;
    logic [vlan_hi-vlan_lo:0]   vlan;
    logic [table_aw-1:0]        rd_addr;
    key_off_t                   off_entry;
    key_mask_t                  mask_entry;

    // free again in the cycle the result leaves
    assign ready_out = !busy || phv_release;
    assign accept    = phv_valid_in && ready_out;
    assign vlan      = phv_in[vlan_hi:vlan_lo];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            lookup    <= 1'b0;
            ext.valid <= 1'b0;
        end else begin
            if (accept) begin
                busy <= 1'b1;
            end else if (phv_release) begin
                busy <= 1'b0;
            end
            lookup    <= accept;
            // entries come back one cycle after the address
            ext.valid <= lookup;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            phv_r   <= phv_in;
            conts_r <= phv_in[phv_len-1 -: $bits(containers_t)];
            rd_addr <= vlan[4 +: table_aw];
        end
    end

    key_table #(
        .table_aw (table_aw),
        .entry_t  (key_off_t)
    ) u_off_table (
        .clk     (clk),
        .wr      (cfg_off_wr),
        .wr_addr (cfg_addr),
        .rd_addr (rd_addr),
        .wr_data (cfg_off_data),
        .rd_data (off_entry)
    );

    key_table #(
        .table_aw (table_aw),
        .entry_t  (key_mask_t)
    ) u_mask_table (
        .clk     (clk),
        .wr      (cfg_mask_wr),
        .wr_addr (cfg_addr),
        .rd_addr (rd_addr),
        .wr_data (cfg_mask_data),
        .rd_data (mask_entry)
    );

    assign ext.phv      = phv_r;
    assign ext.conts    = conts_r;
    assign ext.key_off  = off_entry;
    assign ext.key_mask = mask_entry;

endmodule

`default_nettype wire

//--- project.f
+incdir+test
common/key_extract_pkg.sv
common/extract_if.sv
common/key_if.sv
key_extract/key_table.sv
key_extract/phv_decode.sv
key_extract/key_build.sv
key_extract/key_output.sv
src/key_extract_top.sv
test/tb_key_extract.sv

//--- src/key_extract_top.sv
`timescale 1ns/1ps
`default_nettype none

module key_extract_top import key_extract_pkg::*; #(
    parameter int table_aw = 5
) (
    input  logic                clk,
    input  logic                rst_n,

    input  logic [phv_len-1:0]  phv_in,
    input  logic                phv_valid_in,
    output logic                ready_out,

    input  logic                ready_in,
    output logic [phv_len-1:0]  phv_out,
    output logic                phv_valid_out,
    output logic                key_valid_out,
    output logic [key_len-1:0]  key_out_masked,
    output logic [key_len-1:0]  key_mask_out,

    // table writes, one strobe per entry
    input  logic                cfg_off_wr,
    input  logic                cfg_mask_wr,
    input  logic [table_aw-1:0] cfg_addr,
    input  key_off_t            cfg_off_data,
    input  key_mask_t           cfg_mask_data
);

    logic phv_release;

    extract_if u_ext ();
    key_if     u_key ();

    phv_decode #(
        .table_aw (table_aw)
    ) u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_in        (phv_in),
        .phv_valid_in  (phv_valid_in),
        .ready_out     (ready_out),
        .phv_release   (phv_release),
        .cfg_off_wr    (cfg_off_wr),
        .cfg_mask_wr   (cfg_mask_wr),
        .cfg_addr      (cfg_addr),
        .cfg_off_data  (cfg_off_data),
        .cfg_mask_data (cfg_mask_data),
        .ext           (u_ext.decode)
    );

    key_build u_build (
        .clk   (clk),
        .rst_n (rst_n),
        .ext   (u_ext.build),
        .key   (u_key.build)
    );

    key_output u_output (
        .clk            (clk),
        .rst_n          (rst_n),
        .key            (u_key.out),
        .ready_in       (ready_in),
        .phv_release    (phv_release),
        .phv_out        (phv_out),
        .phv_valid_out  (phv_valid_out),
        .key_valid_out  (key_valid_out),
        .key_out_masked (key_out_masked),
        .key_mask_out   (key_mask_out)
    );

endmodule

`default_nettype wire

//--- test/key_extract_model.svh
`ifndef KEY_EXTRACT_MODEL_SVH
`define KEY_EXTRACT_MODEL_SVH

// blocks from the bottom: metadata, 2B, 4B, 6B
localparam int c2_base = phv_len - $bits(containers_t);
localparam int c4_base = c2_base + 8 * 16;
localparam int c6_base = c4_base + 8 * 32;

// low bit of a container, type 2 = 6B, 1 = 4B, else 2B
function automatic int cont_pos(input logic [1:0] kind, input logic [2:0] idx);
    int pos;
    case (kind)
        2'd2:    pos = c6_base + 48 * int'(idx);
        2'd1:    pos = c4_base + 32 * int'(idx);
        default: pos = c2_base + 16 * int'(idx);
    endcase
    return pos;
endfunction

function automatic logic [47:0] container(input logic [phv_len-1:0] phv,
                                         input logic [1:0] kind, input logic [2:0] idx);
    logic [47:0] res;
    case (kind)
        2'd2:    res = phv[cont_pos(kind, idx) +: 48];
        2'd1:    res = {16'd0, phv[cont_pos(kind, idx) +: 32]};
        2'd0:    res = {32'd0, phv[cont_pos(kind, idx) +: 16]};
        default: res = 48'd0;
    endcase
    return res;
endfunction

// opnd is {imm flag, imm or type and index}
function automatic logic [7:0] operand(input logic [phv_len-1:0] phv, input logic [8:0] opnd);
    logic [47:0] c;
    c = container(phv, opnd[4:3], opnd[2:0]);
    return opnd[8] ? opnd[7:0] : c[7:0];
endfunction

function automatic logic compare(input logic [1:0] op, input logic [7:0] a,
                                 input logic [7:0] b);
    logic res;
    case (op)
        2'd0:    res = a > b;
        2'd1:    res = a >= b;
        2'd2:    res = a == b;
        default: res = 1'b1;
    endcase
    return res;
endfunction

function automatic logic [key_len-1:0] model_key(input logic [phv_len-1:0] phv,
                                                input logic [37:0] off);
    logic [key_len-1:0] k;
    logic [47:0]        c;
    k[192:145] = container(phv, 2'd2, off[37:35]);
    k[144:97]  = container(phv, 2'd2, off[34:32]);
    c          = container(phv, 2'd1, off[31:29]);
    k[96:65]   = c[31:0];
    c          = container(phv, 2'd1, off[28:26]);
    k[64:33]   = c[31:0];
    c          = container(phv, 2'd0, off[25:23]);
    k[32:17]   = c[15:0];
    c          = container(phv, 2'd0, off[22:20]);
    k[16:1]    = c[15:0];
    k[0]       = compare(off[19:18], operand(phv, off[17:9]), operand(phv, off[8:0]));
    return k;
endfunction

`endif

//--- test/tb_key_extract.sv
`timescale 1ns/1ps
`default_nettype none

module tb_key_extract import key_extract_pkg::*; ();

    localparam int table_aw = 5;
    localparam int depth = 2 ** table_aw;
    localparam int off_w = $bits(key_off_t);
    // about four times the length of all tests
    localparam int max_cycles = 4000;

    logic                clk;
    logic                rst_n;
    logic [phv_len-1:0]  phv_in;
    logic                phv_valid_in;
    logic                ready_out;
    logic                ready_in;
    logic [phv_len-1:0]  phv_out;
    logic                phv_valid_out;
    logic                key_valid_out;
    logic [key_len-1:0]  key_out_masked;
    logic [key_len-1:0]  key_mask_out;
    logic                cfg_off_wr;
    logic                cfg_mask_wr;
    logic [table_aw-1:0] cfg_addr;
    logic [off_w-1:0]    cfg_off_data;
    logic [key_len-1:0]  cfg_mask_data;

    logic [off_w-1:0]    off_img [depth];
    logic [key_len-1:0]  mask_img [depth];
    int                  seed = 32'h0b41143a;
    int                  errors = 0;
    int                  prop_errors = 0;
    int                  checks = 0;
    int                  tests = 0;
    int                  cycles = 0;

    `include "key_extract_model.svh"

    key_extract_top #(.table_aw(table_aw)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("timeout: run still busy after %0d cycles", max_cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    valid_pair: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid_out == phv_valid_out)
        else begin
            $display("t=%0t key_valid_out and phv_valid_out differ", $time);
            prop_errors++;
        end

    single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid_out |=> !key_valid_out)
        else begin
            $display("t=%0t valid pulse longer than one cycle", $time);
            prop_errors++;
        end

    ready_with_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid_out |-> ready_out)
        else begin
            $display("t=%0t ready_out not high with the valid pulse", $time);
            prop_errors++;
        end

    held_back: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid_out |-> $past(ready_in))
        else begin
            $display("t=%0t valid pulse without ready_in", $time);
            prop_errors++;
        end

    busy_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
        (phv_valid_in && ready_out) |=> !ready_out)
        else begin
            $display("t=%0t ready_out still high after acceptance", $time);
            prop_errors++;
        end

    task automatic check_val(input string name, input logic [phv_len-1:0] exp,
                             input logic [phv_len-1:0] act);
        checks++;
        assert (act == exp) else begin
            $display("MISMATCH t=%0t %s expected %0h actual %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic rand_vec(output logic [255:0] v);
        for (int i = 0; i < 8; i++) begin
            v[i*32 +: 32] = $random(seed);
        end
    endtask

    task automatic rand_phv(output logic [phv_len-1:0] v, input logic [table_aw-1:0] addr);
        for (int i = 0; i < phv_len / 32; i++) begin
            v[i*32 +: 32] = $random(seed);
        end
        v[vlan_lo+4 +: table_aw] = addr;
    endtask

    task automatic write_entry(input logic [table_aw-1:0] addr, input logic [off_w-1:0] off,
                               input logic [key_len-1:0] mask);
        @(posedge clk);
        cfg_addr      <= addr;
        cfg_off_data  <= off;
        cfg_mask_data <= mask;
        cfg_off_wr    <= 1'b1;
        cfg_mask_wr   <= 1'b1;
        @(posedge clk);
        cfg_off_wr    <= 1'b0;
        cfg_mask_wr   <= 1'b0;
        off_img[addr]  = off;
        mask_img[addr] = mask;
    endtask

    // one PHV through the stage, ready_in low for stall cycles past the first chance
    task automatic run_one(input logic [phv_len-1:0] phv, input int stall);
        logic [table_aw-1:0] addr;
        logic [key_len-1:0]  exp_key;
        int                  edges;
        addr    = phv[vlan_lo+4 +: table_aw];
        exp_key = model_key(phv, off_img[addr]) & ~mask_img[addr];
        edges   = 0;
        @(posedge clk);
        phv_in       <= phv;
        phv_valid_in <= 1'b1;
        ready_in     <= (stall == 0);
        @(negedge clk);
        check_val("ready_out", phv_len'(1'b1), phv_len'(ready_out));
        @(posedge clk);
        phv_valid_in <= 1'b0;
        @(negedge clk);
        while (!key_valid_out) begin
            check_val("ready_out", '0, phv_len'(ready_out));
            @(posedge clk);
            edges++;
            if (edges == 3 + stall) begin
                ready_in <= 1'b1;
            end
            @(negedge clk);
        end
        check_val("latency", phv_len'(4 + stall), phv_len'(edges));
        check_val("phv_out", phv, phv_out);
        check_val("key_out_masked", phv_len'(exp_key), phv_len'(key_out_masked));
        check_val("key_mask_out", phv_len'(mask_img[addr]), phv_len'(key_mask_out));
    endtask

    task automatic report(input string name);
        tests++;
        $display("test %0d %s done, %0d errors so far", tests, name, errors + prop_errors);
    endtask

    function automatic logic [8:0] make_operand(input int kind, input logic [2:0] idx,
                                               input logic [7:0] imm);
        logic [8:0] res;
        if (kind == 4) begin
            res = {1'b1, imm};
        end else begin
            res = {4'b0, kind[1:0], idx};
        end
        return res;
    endfunction

    initial begin
        logic [255:0]       r;
        logic [phv_len-1:0] phv;
        logic [off_w-1:0]   off;
        logic [8:0]         opa;
        logic [8:0]         opb;
        logic [7:0]         a_val;
        logic [7:0]         target;
        rst_n         <= 1'b0;
        phv_in        <= '0;
        phv_valid_in  <= 1'b0;
        ready_in      <= 1'b1;
        cfg_off_wr    <= 1'b0;
        cfg_mask_wr   <= 1'b0;
        cfg_addr      <= '0;
        cfg_off_data  <= '0;
        cfg_mask_data <= '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val("ready_out", phv_len'(1'b1), phv_len'(ready_out));
        check_val("key_valid_out", '0, phv_len'(key_valid_out));
        check_val("phv_valid_out", '0, phv_len'(phv_valid_out));

        // zero masks so the raw key shows
        for (int i = 0; i < depth; i++) begin
            rand_vec(r);
            write_entry(i[table_aw-1:0], r[off_w-1:0], '0);
        end
        for (int i = 0; i < 4; i++) begin
            rand_phv(phv, i[table_aw-1:0]);
            run_one(phv, 0);
        end
        report("handshake");

        for (int i = 0; i < 16; i++) begin
            rand_vec(r);
            rand_phv(phv, r[table_aw-1:0]);
            run_one(phv, 0);
        end
        report("selection");

        for (int op = 0; op < 4; op++) begin
            for (int ta = 0; ta < 5; ta++) begin
                for (int rel = 0; rel < 3; rel++) begin
                    rand_vec(r);
                    rand_phv(phv, 5'd3);
                    opa    = make_operand(ta, r[2:0], r[15:8]);
                    opb    = make_operand((ta + rel + op) % 5, r[5:3], r[23:16]);
                    // b one below, equal to or one above a
                    a_val  = operand(phv, opa);
                    target = a_val + 8'(rel) - 8'd1;
                    if (opb[8]) begin
                        opb[7:0] = target;
                    end else begin
                        phv[cont_pos(opb[4:3], opb[2:0]) +: 8] = target;
                    end
                    write_entry(5'd3, {r[255:238], op[1:0], opa, opb}, '0);
                    run_one(phv, 0);
                end
            end
        end
        report("comparison");

        for (int i = 0; i < depth; i++) begin
            rand_vec(r);
            off = r[off_w-1:0];
            rand_vec(r);
            write_entry(i[table_aw-1:0], off, r[key_len-1:0]);
        end
        for (int i = 0; i < 16; i++) begin
            rand_vec(r);
            rand_phv(phv, r[table_aw-1:0]);
            run_one(phv, 0);
        end
        report("masking");

        for (int i = 0; i < 8; i++) begin
            rand_vec(r);
            rand_phv(phv, r[table_aw-1:0]);
            run_one(phv, 1 + int'(r[10:8]));
        end
        report("back-pressure");

        repeat (2) @(posedge clk);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors + prop_errors);
        if (errors + prop_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
